// File: all.f
src/nlc_pkg.sv
src/fx_mac.sv
src/result_store.sv
src/nlc_control.sv
src/nlc_top.sv
tests/nlc_checker.sv
tests/nlc_monitor.sv
tests/nlc_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module nlc_tb -o nlc_sim \
	&& ./obj_dir/nlc_sim +verilator+error+limit+100 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: src/fx_mac.sv
`timescale 1ns/1ps

module fx_mac
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input mac_op_t op,
	output mac_res_t res
);

	// Product stage contents
	typedef struct packed {
		word_t prod;
		word_t c;
		ch_t ch;
		step_t step;
		logic valid;
	} stage_t;

	stage_t s1;
	word_t scaled;
	word_t sum;

	assign scaled = fx_scale(op.a, op.b);

	// Stage one, scaled product plus addend and tag
	always_ff @(posedge clk) begin
		if (op.valid) begin
			s1.prod <= scaled;
			s1.c <= op.c;
			s1.ch <= op.ch;
			s1.step <= op.step;
		end
		s1.valid <= op.valid;
		if (rst) begin
			s1.valid <= 1'b0;
		end
	end

	// 32-bit wraparound add
	assign sum = s1.prod + s1.c;

	// Stage two, result with tag
	always_ff @(posedge clk) begin
		if (s1.valid) begin
			res.result <= sum;
			res.ch <= s1.ch;
			res.step <= s1.step;
		end
		res.valid <= s1.valid;
		if (rst) begin
			res.valid <= 1'b0;
		end
	end

endmodule

// File: src/nlc_control.sv
`timescale 1ns/1ps

module nlc_control
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input adc_t x_adc [NUM_CH],
	input ch_param_t ch_params [NUM_CH],
	output mac_op_t op,
	input mac_res_t res
);

	ctrl_state_t state;
	ch_t ch_cnt;
	step_t step_cnt;

	logic start;
	logic res_final;

	adc_t x_cap [NUM_CH];
	word_t acc [NUM_CH];
	word_t n_val [NUM_CH];

	ch_param_t prm;
	word_t cur_acc;
	word_t cur_n;
	step_t coeff_idx;
	mac_op_t op_next;

	// New frame only from idle with the previous ack already dropped
	assign start = (state == ST_IDLE) && req && !ack;

	assign res_final = res.valid && (res.step == STEP_LAST) && (res.ch == CH_LAST);

	// Frame FSM with channel index counting fastest
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			ch_cnt <= '0;
			step_cnt <= '0;
			ack <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_RUN;
						ch_cnt <= '0;
						step_cnt <= '0;
					end
				end
				ST_RUN: begin
					if (ch_cnt == CH_LAST) begin
						ch_cnt <= '0;
						if (step_cnt == STEP_LAST) begin
							state <= ST_DRAIN;
						end else begin
							step_cnt <= step_cnt + 1'b1;
						end
					end else begin
						ch_cnt <= ch_cnt + 1'b1;
					end
				end
				ST_DRAIN: begin
					// Last result leaves the pipe, store writes on this edge
					if (res_final) begin
						state <= ST_DONE;
					end
				end
				ST_DONE: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Samples held for the whole frame
	always_ff @(posedge clk) begin
		if (start) begin
			x_cap <= x_adc;
		end
	end

	// Accumulator file, plus n kept from the scale step
	always_ff @(posedge clk) begin
		if (res.valid) begin
			acc[res.ch] <= res.result;
			if (res.step == STEP_SCALE) begin
				n_val[res.ch] <= res.result;
			end
		end
	end

	assign cur_acc = acc[ch_cnt];
	assign cur_n = n_val[ch_cnt];

	assign prm = ch_params[ch_cnt];

	// Horner order, step 3 takes coeff[3] down to coeff[0] at the last step
	assign coeff_idx = STEP_LAST - step_cnt;

	always_comb begin
		op_next.ch = ch_cnt;
		op_next.step = step_cnt;
		op_next.valid = (state == ST_RUN);
		case (step_cnt)
			STEP_OFFSET: begin
				op_next.a = to_word(x_cap[ch_cnt]);
				op_next.b = ONE;
				op_next.c = prm.neg_mean;
			end
			STEP_SCALE: begin
				op_next.a = cur_acc;
				op_next.b = prm.recip_stdev;
				op_next.c = '0;
			end
			STEP_POLY: begin
				op_next.a = prm.coeff[NUM_COEFF-1];
				op_next.b = cur_n;
				op_next.c = prm.coeff[NUM_COEFF-2];
			end
			default: begin
				op_next.a = cur_acc;
				op_next.b = cur_n;
				op_next.c = prm.coeff[coeff_idx];
			end
		endcase
	end

	// Registered issue into fx_mac
	always_ff @(posedge clk) begin
		op <= op_next;
		if (rst) begin
			op.valid <= 1'b0;
		end
	end

endmodule

// File: src/nlc_pkg.sv
package nlc_pkg;

	// Frame geometry
	localparam int NUM_CH = 4;
	localparam int CH_W = $clog2(NUM_CH);
	localparam int NUM_STEPS = 7;
	localparam int STEP_W = 3;
	localparam int NUM_COEFF = 6;

	// Internal word is signed, FRAC_BITS of fraction
	localparam int WORD_W = 32;
	localparam int FRAC_BITS = 21;
	localparam int ADC_W = 21;

	typedef logic signed [WORD_W-1:0] word_t;
	typedef logic [ADC_W-1:0] adc_t;
	typedef logic [CH_W-1:0] ch_t;
	typedef logic [STEP_W-1:0] step_t;

	localparam word_t ONE = word_t'(1 << FRAC_BITS);

	// Step encoding
	localparam step_t STEP_OFFSET = 3'd0;
	localparam step_t STEP_SCALE = 3'd1;
	localparam step_t STEP_POLY = 3'd2;
	localparam step_t STEP_LAST = step_t'(NUM_STEPS - 1);

	localparam ch_t CH_LAST = ch_t'(NUM_CH - 1);

	// Per-channel calibration, coeff[k] multiplies the k-th power
	typedef struct packed {
		word_t neg_mean;
		word_t recip_stdev;
		word_t [NUM_COEFF-1:0] coeff;
	} ch_param_t;

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		ch_t ch;
		step_t step;
		logic valid;
	} mac_op_t;

	typedef struct packed {
		word_t result;
		ch_t ch;
		step_t step;
		logic valid;
	} mac_res_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_DRAIN,
		ST_DONE
	} ctrl_state_t;

	// Raw sample maps onto [0, 1)
	function automatic word_t to_word(adc_t s);
		return word_t'({{(WORD_W - ADC_W){1'b0}}, s});
	endfunction

	// Clamp to the sample range
	function automatic adc_t to_adc(word_t w);
		adc_t s;
		if (w < 0) begin
			s = '0;
		end else if (w >= ONE) begin
			s = '1;
		end else begin
			s = w[ADC_W-1:0];
		end
		return s;
	endfunction

	// Full product, rescaled and truncated to a word
	function automatic word_t fx_scale(word_t a, word_t b);
		logic signed [2*WORD_W-1:0] prod;
		logic signed [2*WORD_W-1:0] shifted;
		prod = a * b;
		shifted = prod >>> FRAC_BITS;
		return shifted[WORD_W-1:0];
	endfunction

	// One multiply-add with wraparound
	function automatic word_t fx_madd(word_t a, word_t b, word_t c);
		word_t sum;
		sum = fx_scale(a, b) + c;
		return sum;
	endfunction

endpackage

// File: src/nlc_top.sv
`timescale 1ns/1ps

module nlc_top
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input adc_t x_adc [NUM_CH],
	input ch_param_t ch_params [NUM_CH],
	output adc_t x_lin [NUM_CH]
);

	mac_op_t op;
	mac_res_t res;

	// Frame handshake, sequencing and accumulators
	nlc_control u_control (
		.clk (clk),
		.rst (rst),
		.req (req),
		.ack (ack),
		.x_adc (x_adc),
		.ch_params (ch_params),
		.op (op),
		.res (res)
	);

	// Shared arithmetic unit
	fx_mac u_mac (
		.clk (clk),
		.rst (rst),
		.op (op),
		.res (res)
	);

	// Output conversion and per-channel sample registers
	result_store u_store (
		.clk (clk),
		.rst (rst),
		.res (res),
		.x_lin (x_lin)
	);

endmodule

// File: src/result_store.sv
`timescale 1ns/1ps

module result_store
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input mac_res_t res,
	output adc_t x_lin [NUM_CH]
);

	logic final_hit;
	adc_t sample;
	logic [NUM_CH-1:0] wr_en;

	// Only the last Horner step carries a finished value
	assign final_hit = res.valid && (res.step == STEP_LAST);
	assign sample = to_adc(res.result);

	genvar i;
	generate
		for (i = 0; i < NUM_CH; i++) begin : g_ch
			assign wr_en[i] = final_hit && (res.ch == ch_t'(i));

			// Holds across frames until the channel finishes again
			always_ff @(posedge clk) begin
				if (rst) begin
					x_lin[i] <= '0;
				end else if (wr_en[i]) begin
					x_lin[i] <= sample;
				end
			end
		end
	endgenerate

endmodule

// File: tests/nlc_checker.sv
`timescale 1ns/1ps

module nlc_checker
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input ctrl_state_t state,
	input mac_res_t res
);

	int fail_count = 0;

	a_ack_after_reset: assert property (@(posedge clk) rst |=> !ack)
		else begin
			$error("ack high in the cycle after reset");
			fail_count++;
		end

	// Four-phase order
	a_ack_fall: assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req))
		else begin
			$error("ack fell while req was still high");
			fail_count++;
		end

	a_ack_rise: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
		else begin
			$error("ack rose while req was low");
			fail_count++;
		end

	a_res_state: assert property (@(posedge clk) disable iff (rst)
		res.valid |-> (state == ST_RUN || state == ST_DRAIN))
		else begin
			$error("result from the MAC outside run and drain");
			fail_count++;
		end

endmodule

bind nlc_control nlc_checker u_chk (
	.clk (clk),
	.rst (rst),
	.req (req),
	.ack (ack),
	.state (state),
	.res (res)
);

// File: tests/nlc_monitor.sv
`timescale 1ns/1ps

module nlc_monitor
	import nlc_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input adc_t x_adc [NUM_CH],
	input ch_param_t ch_params [NUM_CH],
	input adc_t x_lin [NUM_CH],
	output int err_count,
	output int frame_count
);

	localparam int ACK_DELAY = NUM_STEPS * NUM_CH + 4;

	logic in_frame;
	int cycles;
	adc_t exp_lin [NUM_CH];

	// a*b rescaled by 2^-21, then plus c in 32-bit two's complement
	function automatic int mul_add(int a, int b, int c);
		longint prod;
		prod = longint'(a) * longint'(b);
		prod = prod >>> FRAC_BITS;
		return int'(prod) + c;
	endfunction

	function automatic adc_t ref_lin(adc_t x, ch_param_t p);
		int acc;
		int n;
		int k;
		adc_t y;
		acc = mul_add(int'(x), ONE, p.neg_mean);
		n = mul_add(acc, p.recip_stdev, 0);
		// Horner, highest power first
		acc = mul_add(p.coeff[5], n, p.coeff[4]);
		for (k = 3; k >= 0; k--) begin
			acc = mul_add(acc, n, p.coeff[k]);
		end
		if (acc < 0) begin
			y = '0;
		end else if (acc >= ONE) begin
			y = '1;
		end else begin
			y = acc[ADC_W-1:0];
		end
		return y;
	endfunction

	task automatic compare_lin(input string what);
		int i;
		for (i = 0; i < NUM_CH; i++) begin
			if (x_lin[i] !== exp_lin[i]) begin
				$display("** Error at %0t: %s ch %0d expected %h actual %h",
					$time, what, i, exp_lin[i], x_lin[i]);
				err_count++;
			end
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			in_frame = 1'b0;
			cycles = 0;
			err_count = 0;
			frame_count = 0;
			for (int i = 0; i < NUM_CH; i++) begin
				exp_lin[i] = '0;
			end
		end else if (in_frame) begin
			if (ack) begin
				if (cycles != ACK_DELAY) begin
					$display("** Error at %0t: ack rose %0d cycles after req, expected %0d",
						$time, cycles, ACK_DELAY);
					err_count++;
				end
				compare_lin("frame");
				frame_count++;
				in_frame = 1'b0;
			end else begin
				cycles++;
			end
		end else if (req && !ack) begin
			for (int i = 0; i < NUM_CH; i++) begin
				exp_lin[i] = ref_lin(x_adc[i], ch_params[i]);
			end
			cycles = 0;
			in_frame = 1'b1;
		end else begin
			// Outputs hold between frames
			compare_lin("hold");
			if (frame_count == 0 && ack) begin
				$display("** Error at %0t: ack high before any frame", $time);
				err_count++;
			end
		end
	end

endmodule

// File: tests/nlc_tb.sv
`timescale 1ns/1ps

module nlc_tb
	import nlc_pkg::*;
();

	localparam int NUM_FRAMES = 25;
	localparam int CYCLE_LIMIT = 40 * NUM_FRAMES + 100;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	adc_t x_adc [NUM_CH];
	ch_param_t ch_params [NUM_CH];
	adc_t x_lin [NUM_CH];

	int seed;
	int cycles = 0;
	int mon_errors;
	int mon_frames;
	int assert_fails;

	nlc_top u_dut (
		.clk (clk),
		.rst (rst),
		.req (req),
		.ack (ack),
		.x_adc (x_adc),
		.ch_params (ch_params),
		.x_lin (x_lin)
	);

	nlc_monitor u_mon (
		.clk (clk),
		.rst (rst),
		.req (req),
		.ack (ack),
		.x_adc (x_adc),
		.ch_params (ch_params),
		.x_lin (x_lin),
		.err_count (mon_errors),
		.frame_count (mon_frames)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

	// Magnitude below 1.0, either sign
	function automatic word_t small_word();
		int r;
		r = $random(seed);
		return word_t'(r % ONE);
	endfunction

	task automatic random_samples();
		int i;
		for (i = 0; i < NUM_CH; i++) begin
			x_adc[i] = adc_t'($random(seed));
		end
	endtask

	task automatic identity_params();
		int i;
		for (i = 0; i < NUM_CH; i++) begin
			ch_params[i] = '0;
			ch_params[i].recip_stdev = ONE;
			ch_params[i].coeff[1] = ONE;
		end
	endtask

	task automatic random_params();
		int i;
		int k;
		for (i = 0; i < NUM_CH; i++) begin
			ch_params[i].neg_mean = small_word();
			ch_params[i].recip_stdev = small_word();
			for (k = 0; k < NUM_COEFF; k++) begin
				ch_params[i].coeff[k] = small_word();
			end
		end
	endtask

	// Offset added after the identity curve
	task automatic offset_params(input word_t offs);
		int i;
		identity_params();
		for (i = 0; i < NUM_CH; i++) begin
			ch_params[i].coeff[0] = offs;
		end
	endtask

	// Four-phase frame, called 1 ns after an edge with inputs already set
	task automatic run_frame(input int hold);
		req = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!ack);
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		do begin
			@(posedge clk);
			#1;
		end while (ack);
	endtask

	initial begin
		int f;
		seed = 65;
		rst = 1'b1;
		req = 1'b0;
		for (f = 0; f < NUM_CH; f++) begin
			x_adc[f] = '0;
			ch_params[f] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			#1;
		end

		identity_params();
		random_samples();
		run_frame(0);

		for (f = 0; f < 20; f++) begin
			random_params();
			random_samples();
			run_frame(0);
		end

		// Below zero, then above 1.0
		offset_params(-ONE);
		random_samples();
		run_frame(0);
		offset_params(ONE);
		random_samples();
		run_frame(0);

		// Late req release, then a normal frame
		random_params();
		random_samples();
		run_frame(50);
		random_samples();
		run_frame(0);

		repeat (2) begin
			@(posedge clk);
			#1;
		end
		assert_fails = u_dut.u_control.u_chk.fail_count;
		$display("Frames: %0d of %0d, value and timing errors: %0d, assertion failures: %0d",
			mon_frames, NUM_FRAMES, mon_errors, assert_fails);
		if (mon_errors == 0 && assert_fails == 0 && mon_frames == NUM_FRAMES) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
